// File: pixel_pkg.sv
`default_nettype none

package pixel_pkg;

    //////////////////////////////
    // sizes
    //////////////////////////////
    localparam int unsigned num_channels    = 4;
    localparam int unsigned chan_sel_width  = $clog2(num_channels);
    localparam int unsigned adc_bits        = 8;
    localparam int unsigned timestamp_bits  = 16;
    localparam int unsigned chip_id_bits    = 8;
    localparam int unsigned channel_id_bits = 6;
    localparam int unsigned count_bits      = 8;
    localparam int unsigned ptype_bits      = 2;
    localparam int unsigned event_bits      = 42;

    localparam int unsigned fifo_depth      = 4;
    localparam int unsigned fifo_addr_width = $clog2(fifo_depth);

    typedef logic [adc_bits-1:0]          adc_code_t;    // conversion result and trial word
    typedef logic [timestamp_bits-1:0]    timestamp_t;
    typedef logic [chip_id_bits-1:0]      chip_id_t;
    typedef logic [channel_id_bits-1:0]   channel_id_t;
    typedef logic [count_bits-1:0]        count_t;       // hold and reset lengths
    typedef logic [event_bits-1:0]        event_t;
    typedef logic [fifo_addr_width-1:0]   fifo_ptr_t;
    typedef logic [fifo_addr_width:0]     fifo_count_t;  // one extra bit to hold depth

    //////////////////////////////
    // event layout, lsb first
    //////////////////////////////
    localparam int unsigned evt_type_lsb = 0;
    localparam int unsigned evt_chip_lsb = evt_type_lsb + ptype_bits;
    localparam int unsigned evt_chan_lsb = evt_chip_lsb + chip_id_bits;
    localparam int unsigned evt_ts_lsb   = evt_chan_lsb + channel_id_bits;
    localparam int unsigned evt_code_lsb = evt_ts_lsb + timestamp_bits;
    localparam int unsigned evt_ext_lsb  = evt_code_lsb + adc_bits;
    localparam int unsigned evt_full_lsb = evt_ext_lsb + 1;

    localparam logic [ptype_bits-1:0] packet_type_data = 2'b01;

    typedef enum logic [2:0] {
        IDLE, SAMPLE, CONVERT, SAR_DONE, RESET_CSA, STORE
    } chan_state_t;

endpackage

`default_nettype wire

// File: trigger_fanout.sv
`default_nettype none
`timescale 1ns/10ps

module trigger_fanout (
    input  wire logic                                               clk,
    input  wire logic                                               reset_n,
    input  wire logic [pixel_pkg::num_channels-1:0]                 hit,
    input  wire logic [pixel_pkg::num_channels-1:0]                 channel_mask,
    input  wire logic                                               external_trigger,
    input  wire logic                                               external_mask,
    input  wire logic [pixel_pkg::num_channels-1:0]                 chan_ready,
    output logic [pixel_pkg::num_channels-1:0]                      trigger,
    output logic [pixel_pkg::num_channels-1:0]                      trig_external,
    output pixel_pkg::timestamp_t [pixel_pkg::num_channels-1:0]     trig_timestamp
);
    import pixel_pkg::*;

    timestamp_t                timestamp;   // free-running cycle count
    logic [num_channels-1:0]   nat_fire;
    logic                      ext_fire;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            timestamp <= '0;
        end else begin
            timestamp <= timestamp + 1'b1;
        end
    end

    //////////////////////////////
    // masking and fanout
    //////////////////////////////
    always_comb begin
        ext_fire = external_trigger & ~external_mask;
        nat_fire = hit & ~channel_mask;
        for (int i = 0; i < num_channels; i++) begin
            trigger[i]        = (nat_fire[i] | ext_fire) & chan_ready[i];  // idle channels only
            trig_external[i]  = ext_fire & ~nat_fire[i] & chan_ready[i];   // natural wins a tie
            trig_timestamp[i] = timestamp;
        end
    end

endmodule

`default_nettype wire

// File: event_fifo.sv
`default_nettype none
`timescale 1ns/10ps

module event_fifo (
    input  wire logic              clk,
    input  wire logic              reset_n,
    input  wire logic              write,
    input  wire pixel_pkg::event_t write_data,
    input  wire logic              read,
    output pixel_pkg::event_t      read_data,
    output logic                   empty,
    output logic                   full
);
    import pixel_pkg::*;

    event_t      mem [fifo_depth];
    fifo_ptr_t   wr_ptr;
    fifo_ptr_t   rd_ptr;
    fifo_count_t count;        // entries held
    logic        wr_en;
    logic        rd_en;

    assign full      = (count == fifo_count_t'(fifo_depth));
    assign empty     = (count == '0);
    assign wr_en     = write & ~full;    // drop writes when full
    assign rd_en     = read & ~empty;
    assign read_data = mem[rd_ptr];      // first word falls through

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= write_data;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == fifo_ptr_t'(fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == fifo_ptr_t'(fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // idle or simultaneous push/pop
            endcase
        end
    end

endmodule

`default_nettype wire

// File: channel_ctrl.sv
`default_nettype none
`timescale 1ns/10ps

module channel_ctrl #(
    parameter pixel_pkg::channel_id_t channel_id = '0
) (
    input  wire logic                   clk,
    input  wire logic                   reset_n,
    input  wire logic                   trigger,
    input  wire logic                   trig_external,
    input  wire pixel_pkg::timestamp_t  trig_timestamp,
    input  wire logic                   comp,
    input  wire pixel_pkg::count_t      hold_delay,
    input  wire pixel_pkg::count_t      reset_length,
    input  wire pixel_pkg::adc_code_t   digital_threshold,
    input  wire pixel_pkg::chip_id_t    chip_id,
    input  wire logic                   fifo_read,
    output logic                        chan_ready,
    output logic                        sample,
    output logic                        csa_reset,
    output pixel_pkg::adc_code_t        dac_code,
    output logic                        fifo_empty,
    output pixel_pkg::event_t           fifo_data
);
    import pixel_pkg::*;

    chan_state_t state;
    chan_state_t next;
    count_t      cycle_cnt;       // hold and reset countdown
    adc_code_t   sar_mask;        // bit under test, zero outside conversion
    adc_code_t   code;
    timestamp_t  ts_latched;
    logic        ext_latched;
    logic        fifo_full;
    logic        fifo_write;
    event_t      packed_event;

    assign chan_ready = (state == IDLE);
    assign sample     = (state == IDLE) || (state == SAMPLE);
    assign csa_reset  = (state == RESET_CSA);
    assign dac_code   = code | sar_mask;   // trial word while converting

    //////////////////////////////
    // state machine
    //////////////////////////////
    always_comb begin
        next = state;
        case (state)
            IDLE:      if (trigger) next = SAMPLE;
            SAMPLE:    if (cycle_cnt <= count_t'(1)) next = CONVERT;
            CONVERT:   if (sar_mask[0]) next = SAR_DONE;     // lsb trial done
            SAR_DONE:  next = RESET_CSA;
            RESET_CSA: if (cycle_cnt <= count_t'(1)) next = STORE;
            STORE:     next = IDLE;
            default:   next = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state     <= IDLE;
            cycle_cnt <= '0;
            sar_mask  <= '0;
            code      <= '0;
        end else begin
            state <= next;
            case (state)
                IDLE: begin
                    if (trigger) begin
                        cycle_cnt <= hold_delay;
                        code      <= '0;
                    end
                end
                SAMPLE: begin
                    if (next == CONVERT) begin
                        sar_mask <= {1'b1, {(adc_bits-1){1'b0}}};   // start at msb
                    end else begin
                        cycle_cnt <= cycle_cnt - 1'b1;
                    end
                end
                CONVERT: begin
                    if (comp) begin
                        code <= code | sar_mask;   // keep bit
                    end
                    sar_mask <= sar_mask >> 1;
                end
                SAR_DONE: begin
                    cycle_cnt <= reset_length;
                end
                RESET_CSA: begin
                    cycle_cnt <= cycle_cnt - 1'b1;
                end
                default: begin
                end
            endcase
        end
    end

    // trigger info captured with the trigger
    always_ff @(posedge clk) begin
        if (chan_ready && trigger) begin
            ts_latched  <= trig_timestamp;
            ext_latched <= trig_external;
        end
    end

    //////////////////////////////
    // event packing
    //////////////////////////////
    always_comb begin
        packed_event = '0;
        packed_event[evt_type_lsb +: ptype_bits]      = packet_type_data;
        packed_event[evt_chip_lsb +: chip_id_bits]    = chip_id;
        packed_event[evt_chan_lsb +: channel_id_bits] = channel_id;
        packed_event[evt_ts_lsb +: timestamp_bits]    = ts_latched;
        packed_event[evt_code_lsb +: adc_bits]        = code;
        packed_event[evt_ext_lsb]                     = ext_latched;
        packed_event[evt_full_lsb]                    = fifo_full;
    end

    // below threshold or full fifo means the event is lost
    assign fifo_write = (state == STORE) && (code >= digital_threshold) && !fifo_full;

    event_fifo u_fifo (
        .clk        (clk),
        .reset_n    (reset_n),
        .write      (fifo_write),
        .write_data (packed_event),
        .read       (fifo_read),
        .read_data  (fifo_data),
        .empty      (fifo_empty),
        .full       (fifo_full)
    );

endmodule

`default_nettype wire

// File: readout_arbiter.sv
`default_nettype none
`timescale 1ns/10ps

module readout_arbiter (
    input  wire logic                                            clk,
    input  wire logic                                            reset_n,
    input  wire logic [pixel_pkg::num_channels-1:0]              fifo_empty,
    input  wire pixel_pkg::event_t [pixel_pkg::num_channels-1:0] fifo_data,
    input  wire logic                                            event_ack,
    output logic [pixel_pkg::num_channels-1:0]                   fifo_read,
    output logic                                                 event_req,
    output pixel_pkg::event_t                                    event_data
);
    import pixel_pkg::*;

    logic [chan_sel_width-1:0] last_sel;   // last channel served
    logic [chan_sel_width-1:0] next_sel;
    logic                      found;
    logic                      grant;      // pop this cycle

    //////////////////////////////
    // round-robin search
    //////////////////////////////
    always_comb begin
        int unsigned idx;
        found    = 1'b0;
        next_sel = last_sel;
        for (int k = 1; k <= num_channels; k++) begin
            idx = (int'(last_sel) + k) % num_channels;   // start after last served
            if (!found && !fifo_empty[idx]) begin
                found    = 1'b1;
                next_sel = chan_sel_width'(idx);
            end
        end
    end

    // new request only once the previous ack has gone low
    assign grant = found && !event_req && !event_ack;

    always_comb begin
        fifo_read = '0;
        if (grant) begin
            fifo_read[next_sel] = 1'b1;
        end
    end

    //////////////////////////////
    // four-phase output
    //////////////////////////////
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            event_req <= 1'b0;
            last_sel  <= chan_sel_width'(num_channels - 1);   // channel 0 goes first
        end else if (grant) begin
            event_req <= 1'b1;
            last_sel  <= next_sel;
        end else if (event_req && event_ack) begin
            event_req <= 1'b0;   // ack seen, drop request
        end
    end

    // held until the handshake is done
    always_ff @(posedge clk) begin
        if (grant) begin
            event_data <= fifo_data[next_sel];
        end
    end

endmodule

`default_nettype wire

// File: pixel_readout_top.sv
`default_nettype none
`timescale 1ns/10ps

module pixel_readout_top (
    input  wire logic                                               clk,
    input  wire logic                                               reset_n,
    input  wire logic [pixel_pkg::num_channels-1:0]                 hit,
    input  wire logic [pixel_pkg::num_channels-1:0]                 channel_mask,
    input  wire logic                                               external_trigger,
    input  wire logic                                               external_mask,
    input  wire logic [pixel_pkg::num_channels-1:0]                 comp,
    input  wire pixel_pkg::count_t                                  hold_delay,
    input  wire pixel_pkg::count_t                                  reset_length,
    input  wire pixel_pkg::adc_code_t                               digital_threshold,
    input  wire pixel_pkg::chip_id_t                                chip_id,
    input  wire logic                                               event_ack,
    output logic [pixel_pkg::num_channels-1:0]                      sample,
    output logic [pixel_pkg::num_channels-1:0]                      csa_reset,
    output pixel_pkg::adc_code_t [pixel_pkg::num_channels-1:0]      dac_code,
    output logic                                                    event_req,
    output pixel_pkg::event_t                                       event_data
);
    import pixel_pkg::*;

    logic [num_channels-1:0]         trigger;
    logic [num_channels-1:0]         trig_external;
    timestamp_t [num_channels-1:0]   trig_timestamp;
    logic [num_channels-1:0]         chan_ready;
    logic [num_channels-1:0]         fifo_empty;
    logic [num_channels-1:0]         fifo_read;
    event_t [num_channels-1:0]       fifo_data;

    trigger_fanout u_fanout (
        .clk              (clk),
        .reset_n          (reset_n),
        .hit              (hit),
        .channel_mask     (channel_mask),
        .external_trigger (external_trigger),
        .external_mask    (external_mask),
        .chan_ready       (chan_ready),
        .trigger          (trigger),
        .trig_external    (trig_external),
        .trig_timestamp   (trig_timestamp)
    );

    for (genvar i = 0; i < num_channels; i++) begin : g_channel
        channel_ctrl #(
            .channel_id (channel_id_t'(i))
        ) u_channel (
            .clk               (clk),
            .reset_n           (reset_n),
            .trigger           (trigger[i]),
            .trig_external     (trig_external[i]),
            .trig_timestamp    (trig_timestamp[i]),
            .comp              (comp[i]),
            .hold_delay        (hold_delay),
            .reset_length      (reset_length),
            .digital_threshold (digital_threshold),
            .chip_id           (chip_id),
            .fifo_read         (fifo_read[i]),
            .chan_ready        (chan_ready[i]),
            .sample            (sample[i]),
            .csa_reset         (csa_reset[i]),
            .dac_code          (dac_code[i]),
            .fifo_empty        (fifo_empty[i]),
            .fifo_data         (fifo_data[i])
        );
    end

    readout_arbiter u_arbiter (
        .clk        (clk),
        .reset_n    (reset_n),
        .fifo_empty (fifo_empty),
        .fifo_data  (fifo_data),
        .event_ack  (event_ack),
        .fifo_read  (fifo_read),
        .event_req  (event_req),
        .event_data (event_data)
    );

endmodule

`default_nettype wire

// File: pixel_readout_checker.sv
`default_nettype none
`timescale 1ns/10ps

module pixel_readout_checker (
    input wire logic                clk,
    input wire logic                reset_n,
    input wire logic                event_req,
    input wire logic                event_ack,
    input wire pixel_pkg::event_t   event_data,
    input wire pixel_pkg::chip_id_t chip_id
);
    import pixel_pkg::*;

    int assert_fails = 0;   // summed into the closing report

    // no new request while the previous ack is still high
    req_after_ack_low: assert property (@(posedge clk) disable iff (!reset_n)
        !event_req && event_ack |=> !event_req)
        else begin
            $error("event_req rose while event_ack was high");
            assert_fails++;
        end

    req_data_held: assert property (@(posedge clk) disable iff (!reset_n)
        event_req && !event_ack |=> event_req && $stable(event_data))
        else begin
            $error("event_req or event_data changed before event_ack");
            assert_fails++;
        end

    req_drops_on_ack: assert property (@(posedge clk) disable iff (!reset_n)
        event_req && event_ack |=> !event_req)
        else begin
            $error("event_req stayed high after event_ack");
            assert_fails++;
        end

    // packet type, chip id and a valid channel id
    event_header: assert property (@(posedge clk) disable iff (!reset_n)
        event_req |-> (event_data[1:0] == 2'b01) && (event_data[9:2] == chip_id)
                      && (event_data[15:10] < num_channels))
        else begin
            $error("event_data header 0x%0h is malformed", event_data[15:0]);
            assert_fails++;
        end

endmodule

bind pixel_readout_top pixel_readout_checker u_checker (
    .clk        (clk),
    .reset_n    (reset_n),
    .event_req  (event_req),
    .event_ack  (event_ack),
    .event_data (event_data),
    .chip_id    (chip_id)
);

`default_nettype wire

// File: tb_pixel_readout.sv
`default_nettype none
`timescale 1ns/10ps

module tb_pixel_readout;
    import pixel_pkg::*;

    localparam int wait_limit = 500;   // cycles allowed per wait

    logic                          clk;
    logic                          reset_n;
    logic [num_channels-1:0]       hit;
    logic [num_channels-1:0]       channel_mask;
    logic                          external_trigger;
    logic                          external_mask;
    logic [num_channels-1:0]       comp;
    count_t                        hold_delay;
    count_t                        reset_length;
    adc_code_t                     digital_threshold;
    chip_id_t                      chip_id;
    logic                          event_ack = 1'b0;
    logic [num_channels-1:0]       sample;
    logic [num_channels-1:0]       csa_reset;
    adc_code_t [num_channels-1:0]  dac_code;
    logic                          event_req;
    event_t                        event_data;

    adc_code_t   vin [num_channels];             // analog level seen by each channel
    event_t      events [$];                     // accepted output events
    timestamp_t  edge_count;
    logic [31:0] lfsr_state = 32'h862c_7a70;
    logic [7:0]  ack_delay = '0;
    logic        ack_enable = 1'b1;
    int          check_errors = 0;
    int          timeout_errors = 0;

    pixel_readout_top u_dut (
        .clk               (clk),
        .reset_n           (reset_n),
        .hit               (hit),
        .channel_mask      (channel_mask),
        .external_trigger  (external_trigger),
        .external_mask     (external_mask),
        .comp              (comp),
        .hold_delay        (hold_delay),
        .reset_length      (reset_length),
        .digital_threshold (digital_threshold),
        .chip_id           (chip_id),
        .event_ack         (event_ack),
        .sample            (sample),
        .csa_reset         (csa_reset),
        .dac_code          (dac_code),
        .event_req         (event_req),
        .event_data        (event_data)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    // taps 32 22 2 1
    function automatic logic lfsr_next_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [7:0] random_bits(input int n);
        logic [7:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[6:0], lfsr_next_bit()};
        end
        return v;
    endfunction

    always @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            edge_count <= '0;
        end else begin
            edge_count <= edge_count + 1'b1;   // rising edges since release
        end
    end

    //////////////////////////////
    // comparator and ack responder
    //////////////////////////////
    always @(negedge clk) begin
        for (int i = 0; i < num_channels; i++) begin
            comp[i] <= (vin[i] >= dac_code[i]);
        end
    end

    always @(negedge clk) begin
        if (event_req && !event_ack && ack_enable) begin
            if (ack_delay == 0) begin
                event_ack <= 1'b1;
                events.push_back(event_data);
                ack_delay <= random_bits(2);   // 0 to 3 cycles before ack drops
            end else begin
                ack_delay <= ack_delay - 1'b1;
            end
        end else if (!event_req && event_ack) begin
            if (ack_delay == 0) begin
                event_ack <= 1'b0;
                ack_delay <= random_bits(2);   // 0 to 3 cycles before the next ack
            end else begin
                ack_delay <= ack_delay - 1'b1;
            end
        end
    end

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp);
            check_errors++;
        end
    endtask

    // fields by position, lsb first
    task automatic check_event(input event_t ev, input int ch, input timestamp_t ts,
                               input logic ext);
        check_value("event_data.packet_type", ev[1:0], 2'b01);
        check_value("event_data.chip_id", ev[9:2], chip_id);
        check_value("event_data.channel_id", ev[15:10], ch);
        check_value("event_data.timestamp", ev[31:16], ts);
        check_value("event_data.adc_code", ev[39:32], vin[ch]);
        check_value("event_data.trigger_type", ev[40], ext);
        check_value("event_data.fifo_full", ev[41], 1'b0);
    endtask

    task automatic check_channel_events(input int start, input int ch, input int exp_count,
                                        input timestamp_t ts, input logic ext);
        int found;
        int first;
        found = 0;
        first = -1;
        for (int i = start; i < events.size(); i++) begin
            if (events[i][15:10] == ch) begin
                first = (first < 0) ? i : first;
                found++;
            end
        end
        check_value($sformatf("event count ch%0d", ch), found, exp_count);
        if (first >= 0 && exp_count > 0) begin
            check_event(events[first], ch, ts, ext);
        end
    endtask

    task automatic pulse_trigger(input logic [num_channels-1:0] hits, input logic ext,
                                 output timestamp_t ts);
        @(negedge clk);
        ts = edge_count;   // value the counter holds at the next rising edge
        hit = hits;
        external_trigger = ext;
        @(negedge clk);
        hit = '0;
        external_trigger = 1'b0;
    endtask

    task automatic wait_busy(input logic [num_channels-1:0] mask);
        int n;
        n = 0;
        while ((sample & mask) != '0 && n < wait_limit) begin
            @(negedge clk);
            n++;
        end
        if ((sample & mask) != '0) begin
            $display("Timeout: channels %b never started converting", mask);
            timeout_errors++;
        end
    endtask

    // also counts the csa reset cycles of one conversion
    task automatic wait_idle(input logic [num_channels-1:0] mask);
        int n;
        int reset_cycles;
        n = 0;
        reset_cycles = 0;
        while (((sample & mask) != mask || (csa_reset & mask) != '0) && n < wait_limit) begin
            @(negedge clk);
            n++;
            if ((csa_reset & mask) != '0) begin
                reset_cycles++;
            end
        end
        if ((sample & mask) != mask || (csa_reset & mask) != '0) begin
            $display("Timeout: channels %b did not return to idle", mask);
            timeout_errors++;
        end else begin
            check_value("csa_reset high cycles", reset_cycles,
                        (reset_length == '0) ? 1 : reset_length);
        end
    endtask

    // all idle and no handshake activity for a few cycles
    task automatic wait_quiet();
        int quiet;
        int n;
        quiet = 0;
        n = 0;
        while (quiet < 8 && n < wait_limit) begin
            @(negedge clk);
            n++;
            if (&sample && csa_reset == '0 && !event_req && !event_ack) begin
                quiet++;
            end else begin
                quiet = 0;
            end
        end
        if (quiet < 8) begin
            $display("Timeout: the readout did not drain and go quiet");
            timeout_errors++;
        end
    endtask

    //////////////////////////////
    // stimulus
    //////////////////////////////
    initial begin
        timestamp_t ts;
        timestamp_t bp_ts [6];
        int         start;
        int         total;
        reset_n = 1'b0;
        hit = '0;
        channel_mask = '0;
        external_trigger = 1'b0;
        external_mask = 1'b0;
        comp = '0;
        hold_delay = 8'd3;
        reset_length = 8'd2;
        digital_threshold = 8'h40;
        chip_id = 8'ha5;
        for (int i = 0; i < num_channels; i++) begin
            vin[i] = '0;
        end
        repeat (2) @(negedge clk);
        reset_n = 1'b1;

        // natural hits, code and timestamp
        for (int ch = 0; ch < num_channels; ch++) begin
            vin[ch] = random_bits(8) | 8'h40;
            start = events.size();
            pulse_trigger(4'b0001 << ch, 1'b0, ts);
            wait_busy(4'b0001 << ch);
            wait_quiet();
            check_value("event count", events.size() - start, 1);
            check_channel_events(start, ch, 1, ts, 1'b0);
        end

        vin[1] = random_bits(8) & 8'h3f;   // below threshold
        start = events.size();
        pulse_trigger(4'b0010, 1'b0, ts);
        wait_busy(4'b0010);
        wait_quiet();
        check_value("event count below threshold", events.size() - start, 0);
        vin[1] = random_bits(8) | 8'h40;

        channel_mask = 4'b0100;
        start = events.size();
        pulse_trigger(4'b0100, 1'b0, ts);
        wait_quiet();
        check_value("event count masked hit", events.size() - start, 0);

        start = events.size();
        pulse_trigger('0, 1'b1, ts);
        wait_busy('1);
        wait_quiet();
        check_value("event count external", events.size() - start, num_channels);
        for (int ch = 0; ch < num_channels; ch++) begin
            check_channel_events(start, ch, 1, ts, 1'b1);
        end

        external_mask = 1'b1;
        start = events.size();
        pulse_trigger('0, 1'b1, ts);
        wait_quiet();
        check_value("event count masked external", events.size() - start, 0);
        external_mask = 1'b0;
        channel_mask = '0;

        // back-pressure, the sixth hit finds the fifo full
        ack_enable = 1'b0;
        start = events.size();
        for (int n = 0; n < 6; n++) begin
            pulse_trigger(4'b1000, 1'b0, bp_ts[n]);
            wait_busy(4'b1000);
            wait_idle(4'b1000);
        end
        check_value("event_req while stalled", event_req, 1'b1);   // first event held
        ack_enable = 1'b1;
        wait_quiet();
        check_value("event count after stall", events.size() - start, fifo_depth + 1);
        for (int n = 0; n < fifo_depth + 1 && start + n < events.size(); n++) begin
            check_event(events[start + n], 3, bp_ts[n], 1'b0);
        end

        total = check_errors + timeout_errors + u_dut.u_checker.assert_fails;
        $display("errors: checks %0d, timeouts %0d, assertions %0d",
                 check_errors, timeout_errors, u_dut.u_checker.assert_fails);
        if (total == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
pixel_pkg.sv
trigger_fanout.sv
event_fifo.sv
channel_ctrl.sv
readout_arbiter.sv
pixel_readout_top.sv
pixel_readout_checker.sv
tb_pixel_readout.sv

// File: Bender.yml
package:
  name: pixel_readout

sources:
  - pixel_pkg.sv
  - trigger_fanout.sv
  - event_fifo.sv
  - channel_ctrl.sv
  - readout_arbiter.sv
  - pixel_readout_top.sv
  - target: test
    files:
      - pixel_readout_checker.sv
      - tb_pixel_readout.sv
